// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ics_periph
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	-./$(OBJ_DIR)/sim_$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
hdl/periph_bus_pkg.sv
hdl/flash_pkg.sv
hdl/periph_bus_if.sv
hdl/flash_bit_counter.sv
hdl/flash_read_fsm.sv
hdl/cpu_irq_control.sv
hdl/dsp_multiplier.sv
hdl/mmio_responder.sv
hdl/address_decoder.sv
hdl/ics_periph_top.sv
tb/ics_periph_sva.sv
tb/tb_ics_periph.sv

// File: hdl/address_decoder.sv
//////////////////////////////////////////////////////////////////////
// One access in flight at a time. The host must hold mem_valid and
// its payload until mem_ready, then drop mem_valid for a cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module address_decoder (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  logic mem_valid,
    input  periph_bus_pkg::addr_t mem_address,
    input  periph_bus_pkg::data_t mem_write_data,
    input  periph_bus_pkg::wstrb_t mem_wstrb,
    input  logic mem_ready,
    periph_bus_if.decoder bus
);
    logic busy;
    logic accept;
    periph_bus_pkg::region_t region;

    assign accept = mem_valid && !busy;
    assign region = periph_bus_pkg::region_t'(
        mem_address[periph_bus_pkg::region_lsb +: $bits(periph_bus_pkg::region_t)]);

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            busy <= 1'b0;
            bus.sel_status <= 1'b0;
            bus.sel_dsp <= 1'b0;
            bus.sel_irq <= 1'b0;
            bus.sel_flash <= 1'b0;
            bus.sel_none <= 1'b0;
        end else begin
            // selects only last one cycle
            bus.sel_status <= accept && (region == periph_bus_pkg::region_status);
            bus.sel_dsp <= accept && (region == periph_bus_pkg::region_dsp);
            bus.sel_irq <= accept && (region == periph_bus_pkg::region_irq);
            bus.sel_flash <= accept && (region == periph_bus_pkg::region_flash);
            bus.sel_none <= accept && !(region inside {periph_bus_pkg::region_status,
                periph_bus_pkg::region_dsp, periph_bus_pkg::region_irq,
                periph_bus_pkg::region_flash});

            if (accept) begin
                busy <= 1'b1;
            end else if (mem_ready) begin
                busy <= 1'b0;
            end
        end
    end

    // payload held for the targets
    always_ff @(posedge vdp_clk) begin
        if (accept) begin
            bus.address <= mem_address;
            bus.write_data <= mem_write_data;
            bus.wstrb <= mem_wstrb;
            bus.write <= |mem_wstrb;
        end
    end

endmodule

// File: hdl/cpu_irq_control.sv
//////////////////////////////////////////////////////////////////////
// Two level interrupts: bit 0 frame, bit 1 raster. Events are pulses;
// a write to the irq region clears the bits named in data 1..0.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_irq_control (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  logic frame_ended,
    input  logic raster_hit,
    periph_bus_if.target bus,
    output logic [1:0] pending,
    output logic [1:0] irq
);
    logic [1:0] event_r;
    logic [1:0] ack;

    assign ack = (bus.sel_irq && bus.write) ? bus.write_data[1:0] : 2'b00;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            event_r <= 2'b00;
            pending <= 2'b00;
        end else begin
            event_r <= {raster_hit, frame_ended};
            // a new event beats an acknowledge in the same cycle
            pending <= (pending & ~ack) | event_r;
        end
    end

    assign irq = pending;

endmodule

// File: hdl/dsp_multiplier.sv
//////////////////////////////////////////////////////////////////////
// Signed 16x16 multiply. Operands come from data bits 15..0, the
// product follows an operand change by one cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dsp_multiplier (
    input  logic vdp_clk,
    periph_bus_if.target bus,
    output periph_bus_pkg::data_t product
);
    logic [15:0] operand_a;
    logic [15:0] operand_b;
    logic load_a;
    logic load_b;

    assign load_a = bus.sel_dsp && bus.write && !bus.address[periph_bus_pkg::dsp_operand_b_bit];
    assign load_b = bus.sel_dsp && bus.write && bus.address[periph_bus_pkg::dsp_operand_b_bit];

    // flat enables so the operands map onto the DSP input registers
    always_ff @(posedge vdp_clk) begin
        if (load_a) begin
            operand_a <= bus.write_data[15:0];
        end
        if (load_b) begin
            operand_b <= bus.write_data[15:0];
        end

        product <= $signed(operand_a) * $signed(operand_b);
    end

endmodule

// File: hdl/flash_bit_counter.sv
//////////////////////////////////////////////////////////////////////
// Bits left in the current SPI phase. load takes priority over
// shift_en; last_bit marks the final bit of the phase.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module flash_bit_counter (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  logic load,
    input  flash_pkg::bit_count_t bit_count,
    input  logic shift_en,
    output logic last_bit
);
    flash_pkg::bit_count_t count;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            count <= '0;
        end else if (load) begin
            count <= bit_count;
        end else if (shift_en && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // one bit remaining
    assign last_bit = (count == flash_pkg::bit_count_t'(1));

endmodule

// File: hdl/flash_pkg.sv
//////////////////////////////////////////////////////////////////////
// SPI flash single-read protocol: command, field lengths, FSM states.
// Only the plain 03h read is supported, no fast read or dummy bits.
//////////////////////////////////////////////////////////////////////

package flash_pkg;

    localparam logic [7:0] flash_read_cmd = 8'h03;

    localparam int cmd_bits  = 8;
    localparam int addr_bits = 24;
    localparam int data_bits = 32;

    // wide enough for the longest phase
    typedef logic [5:0] bit_count_t;

    typedef enum logic [2:0] {
        idle,
        command,
        address,
        data,
        finish
    } flash_state_t;

endpackage

// File: hdl/flash_read_fsm.sv
//////////////////////////////////////////////////////////////////////
// SPI single read: 03h, 24-bit address, 32 data bits. sck is half of
// vdp_clk, mosi moves while sck is low, miso is taken on sck rise.
// Only FLASH_ADDR_BITS low address bits reach the flash.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module flash_read_fsm #(
    parameter int FLASH_ADDR_BITS = 20
) (
    input  logic vdp_clk,
    input  logic vdp_reset,
    periph_bus_if.target bus,
    input  logic last_bit,
    output logic load,
    output flash_pkg::bit_count_t bit_count,
    output logic shift_en,
    output periph_bus_pkg::data_t flash_data,
    output logic flash_done,
    output logic flash_sck,
    output logic flash_csn,
    output logic flash_mosi,
    input  logic flash_miso
);
    localparam int tx_bits = flash_pkg::cmd_bits + flash_pkg::addr_bits;

    flash_pkg::flash_state_t state;
    logic [flash_pkg::addr_bits-1:0] spi_addr;
    logic [tx_bits-1:0] tx_shift;
    logic [flash_pkg::data_bits-1:0] rx_shift;
    logic start;
    logic shifting;
    logic phase_end;

    assign start = bus.sel_flash && !bus.write;
    assign shifting = state inside {flash_pkg::command, flash_pkg::address, flash_pkg::data};
    // bit ends when sck falls
    assign shift_en = shifting && flash_sck;
    assign phase_end = shift_en && last_bit;

    always_comb begin
        spi_addr = '0;
        spi_addr[FLASH_ADDR_BITS-1:0] = bus.address[FLASH_ADDR_BITS-1:0];
    end

    always_comb begin
        load = 1'b0;
        bit_count = '0;
        if (state == flash_pkg::idle && start) begin
            load = 1'b1;
            bit_count = flash_pkg::bit_count_t'(flash_pkg::cmd_bits);
        end else if (state == flash_pkg::command && phase_end) begin
            load = 1'b1;
            bit_count = flash_pkg::bit_count_t'(flash_pkg::addr_bits);
        end else if (state == flash_pkg::address && phase_end) begin
            load = 1'b1;
            bit_count = flash_pkg::bit_count_t'(flash_pkg::data_bits);
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= flash_pkg::idle;
            flash_csn <= 1'b1;
            flash_sck <= 1'b0;
            flash_done <= 1'b0;
            tx_shift <= '0;
        end else begin
            flash_done <= 1'b0;
            case (state)
                flash_pkg::idle: begin
                    if (start) begin
                        flash_csn <= 1'b0;
                        tx_shift <= {flash_pkg::flash_read_cmd, spi_addr};
                        state <= flash_pkg::command;
                    end
                end
                flash_pkg::command, flash_pkg::address, flash_pkg::data: begin
                    flash_sck <= !flash_sck;
                    if (flash_sck) begin
                        tx_shift <= tx_shift << 1;
                    end
                    if (phase_end) begin
                        case (state)
                            flash_pkg::command: state <= flash_pkg::address;
                            flash_pkg::address: state <= flash_pkg::data;
                            default: state <= flash_pkg::finish;
                        endcase
                    end
                end
                default: begin
                    flash_csn <= 1'b1;
                    flash_done <= 1'b1;
                    state <= flash_pkg::idle;
                end
            endcase
        end
    end

    // sample on the cycle sck rises
    always_ff @(posedge vdp_clk) begin
        if (state == flash_pkg::data && !flash_sck) begin
            rx_shift <= {rx_shift[flash_pkg::data_bits-2:0], flash_miso};
        end
    end

    assign flash_mosi = tx_shift[tx_bits-1];

    // first byte in lands in bits 7..0
    assign flash_data = {rx_shift[7:0], rx_shift[15:8], rx_shift[23:16], rx_shift[31:24]};

endmodule

// File: hdl/ics_periph_top.sv
//////////////////////////////////////////////////////////////////////
// CPU-side peripheral block, single clock domain (vdp_clk).
// Regions: 1 status, 2 dsp, 3 irq, 4 flash read; others read zero.
// No back-pressure: the host waits for mem_ready.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ics_periph_top #(
    parameter int FLASH_ADDR_BITS = 20,
    parameter logic [1:0] STATUS_RESET = 2'b01
) (
    input  logic vdp_clk,
    input  logic vdp_reset,

    input  logic mem_valid,
    input  periph_bus_pkg::addr_t mem_address,
    input  periph_bus_pkg::data_t mem_write_data,
    input  periph_bus_pkg::wstrb_t mem_wstrb,
    output logic mem_ready,
    output periph_bus_pkg::data_t mem_read_data,

    input  logic frame_ended,
    input  logic raster_hit,
    output logic [1:0] irq,

    output logic led_r,
    output logic led_b,

    output logic flash_sck,
    output logic flash_csn,
    output logic flash_mosi,
    input  logic flash_miso
);
    periph_bus_if bus ();

    periph_bus_pkg::data_t product;
    periph_bus_pkg::data_t flash_data;
    logic [1:0] pending;
    logic flash_done;

    logic load;
    logic shift_en;
    logic last_bit;
    flash_pkg::bit_count_t bit_count;

    address_decoder u_decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_address(mem_address),
        .mem_write_data(mem_write_data),
        .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready),
        .bus(bus.decoder)
    );

    mmio_responder #(
        .STATUS_RESET(STATUS_RESET)
    ) u_responder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.target),
        .product(product),
        .pending(pending),
        .flash_data(flash_data),
        .flash_done(flash_done),
        .mem_ready(mem_ready),
        .mem_read_data(mem_read_data),
        .led_r(led_r),
        .led_b(led_b)
    );

    dsp_multiplier u_dsp (
        .vdp_clk(vdp_clk),
        .bus(bus.target),
        .product(product)
    );

    cpu_irq_control u_irq (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .frame_ended(frame_ended),
        .raster_hit(raster_hit),
        .bus(bus.target),
        .pending(pending),
        .irq(irq)
    );

    flash_read_fsm #(
        .FLASH_ADDR_BITS(FLASH_ADDR_BITS)
    ) u_flash_fsm (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .bus(bus.target),
        .last_bit(last_bit),
        .load(load),
        .bit_count(bit_count),
        .shift_en(shift_en),
        .flash_data(flash_data),
        .flash_done(flash_done),
        .flash_sck(flash_sck),
        .flash_csn(flash_csn),
        .flash_mosi(flash_mosi),
        .flash_miso(flash_miso)
    );

    flash_bit_counter u_bit_counter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .load(load),
        .bit_count(bit_count),
        .shift_en(shift_en),
        .last_bit(last_bit)
    );

endmodule

// File: hdl/mmio_responder.sv
//////////////////////////////////////////////////////////////////////
// Status LEDs, read-data mux and mem_ready. Register regions answer
// two cycles after acceptance; flash reads answer on flash_done.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mmio_responder #(
    parameter logic [1:0] STATUS_RESET = 2'b01
) (
    input  logic vdp_clk,
    input  logic vdp_reset,
    periph_bus_if.target bus,
    input  periph_bus_pkg::data_t product,
    input  logic [1:0] pending,
    input  periph_bus_pkg::data_t flash_data,
    input  logic flash_done,
    output logic mem_ready,
    output periph_bus_pkg::data_t mem_read_data,
    output logic led_r,
    output logic led_b
);
    logic [1:0] status;
    logic quick_sel;
    logic quick_ready;
    periph_bus_pkg::data_t read_next;
    periph_bus_pkg::data_t reg_read_data;

    // flash writes are dropped but still need an answer
    assign quick_sel = bus.sel_status || bus.sel_dsp || bus.sel_irq || bus.sel_none
        || (bus.sel_flash && bus.write);

    assign led_r = status[0];
    assign led_b = status[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= STATUS_RESET;
            quick_ready <= 1'b0;
        end else begin
            quick_ready <= quick_sel;
            if (bus.sel_status && bus.write) begin
                status <= bus.write_data[1:0];
            end
        end
    end

    always_comb begin
        if (bus.sel_status) begin
            read_next = {30'b0, status};
        end else if (bus.sel_dsp) begin
            read_next = product;
        end else if (bus.sel_irq) begin
            read_next = {30'b0, pending};
        end else begin
            read_next = periph_bus_pkg::unmapped_read_value;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (quick_sel) begin
            reg_read_data <= read_next;
        end
    end

    assign mem_ready = quick_ready || flash_done;
    assign mem_read_data = flash_done ? flash_data : reg_read_data;

endmodule

// File: hdl/periph_bus_if.sv
//////////////////////////////////////////////////////////////////////
// Held CPU access plus one-cycle region selects, decoder to targets.
// Payload stays valid from acceptance until the access completes.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface periph_bus_if;

    periph_bus_pkg::addr_t address;
    periph_bus_pkg::data_t write_data;
    periph_bus_pkg::wstrb_t wstrb;
    logic write;

    logic sel_status;
    logic sel_dsp;
    logic sel_irq;
    logic sel_flash;
    logic sel_none;

    modport decoder (
        output address, write_data, wstrb, write,
        output sel_status, sel_dsp, sel_irq, sel_flash, sel_none
    );

    modport target (
        input address, write_data, wstrb, write,
        input sel_status, sel_dsp, sel_irq, sel_flash, sel_none
    );

endinterface

// File: hdl/periph_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// CPU bus widths and the peripheral address map.
// Region is taken from the top address nibble; other codes are
// unmapped and read back as unmapped_read_value.
//////////////////////////////////////////////////////////////////////

package periph_bus_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0] wstrb_t;

    // address bits 23..20
    typedef enum logic [3:0] {
        region_status = 4'd1,
        region_dsp    = 4'd2,
        region_irq    = 4'd3,
        region_flash  = 4'd4
    } region_t;

    localparam int region_lsb = 20;

    // picks operand b over operand a in the dsp region
    localparam int dsp_operand_b_bit = 2;

    localparam data_t unmapped_read_value = '0;

endpackage

// File: tb/ics_periph_sva.sv
//////////////////////////////////////////////////////////////////////
// Timing checks bound into ics_periph_top: reset values, the two-cycle
// ready, the single ready pulse, irq latency and SPI chip select.
// Reset values assume STATUS_RESET at its default of 2'b01.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ics_periph_sva (
    input  logic vdp_clk,
    input  logic vdp_reset,
    input  logic mem_valid,
    input  periph_bus_pkg::addr_t mem_address,
    input  periph_bus_pkg::wstrb_t mem_wstrb,
    input  logic mem_ready,
    input  logic frame_ended,
    input  logic raster_hit,
    input  logic [1:0] irq,
    input  logic led_r,
    input  logic led_b,
    input  logic flash_sck,
    input  logic flash_csn,
    input  logic flash_done
);
    int unsigned fail_count = 0;
    logic flash_read_req;
    logic [1:0] irq_events;

    assign flash_read_req = (mem_address[23:20] == periph_bus_pkg::region_flash)
        && (mem_wstrb == 4'b0000);
    assign irq_events = {raster_hit, frame_ended};

    reset_values: assert property (@(posedge vdp_clk)
        vdp_reset |=> led_r && !led_b && irq == 2'b00 && flash_csn && !flash_sck && !mem_ready)
    else begin
        fail_count++;
        $error("outputs not at their reset values after a reset cycle");
    end

    // acceptance is the rise of mem_valid, the decoder is idle by then
    ready_two_cycles: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(mem_valid) && !flash_read_req |-> !mem_ready ##1 !mem_ready ##1 mem_ready)
    else begin
        fail_count++;
        $error("mem_ready did not come exactly two cycles after acceptance");
    end

    ready_pulse: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |-> mem_valid ##1 !mem_ready)
    else begin
        fail_count++;
        $error("mem_ready was high without mem_valid or longer than one cycle");
    end

    for (genvar g = 0; g < 2; g++) begin : g_irq
        irq_latency: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
            irq_events[g] |-> ##2 irq[g])
        else begin
            fail_count++;
            $error("irq bit %0d did not rise two cycles after its event", g);
        end
    end

    flash_start: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(mem_valid) && flash_read_req |-> ##2 $fell(flash_csn))
    else begin
        fail_count++;
        $error("flash_csn did not fall after a flash read was accepted");
    end

    // csn may only rise with the done pulse
    csn_framing: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(flash_csn) |-> flash_done)
    else begin
        fail_count++;
        $error("flash_csn rose before the transfer finished");
    end

    sck_idle: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        flash_csn |-> !flash_sck)
    else begin
        fail_count++;
        $error("flash_sck was high while flash_csn was high");
    end

endmodule

// File: tb/tb_ics_periph.sv
//////////////////////////////////////////////////////////////////////
// Testbench for ics_periph_top: bus host tasks, an SPI flash model
// for 03h reads and LFSR stimulus. Values are checked here, timing
// in the bound ics_periph_sva. Expects FLASH_ADDR_BITS of 20.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ics_periph;

    localparam int bus_timeout = 400;
    localparam int flash_addr_bits = 20;

    logic vdp_clk;
    logic vdp_reset;
    logic mem_valid;
    periph_bus_pkg::addr_t mem_address;
    periph_bus_pkg::data_t mem_write_data;
    periph_bus_pkg::wstrb_t mem_wstrb;
    logic mem_ready;
    periph_bus_pkg::data_t mem_read_data;
    logic frame_ended;
    logic raster_hit;
    logic [1:0] irq;
    logic led_r;
    logic led_b;
    logic flash_sck;
    logic flash_csn;
    logic flash_mosi;
    logic flash_miso;

    int value_errors;
    int timeouts;
    logic [15:0] lfsr_state;

    // flash model
    logic [31:0] spi_rx;
    logic [7:0] tx_byte;
    int rx_bits;
    int tx_bits;
    int sck_rises;

    ics_periph_top u_dut (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_address(mem_address),
        .mem_write_data(mem_write_data),
        .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready),
        .mem_read_data(mem_read_data),
        .frame_ended(frame_ended),
        .raster_hit(raster_hit),
        .irq(irq),
        .led_r(led_r),
        .led_b(led_b),
        .flash_sck(flash_sck),
        .flash_csn(flash_csn),
        .flash_mosi(flash_mosi),
        .flash_miso(flash_miso)
    );

    bind ics_periph_top ics_periph_sva u_sva (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_address(mem_address),
        .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready),
        .frame_ended(frame_ended),
        .raster_hit(raster_hit),
        .irq(irq),
        .led_r(led_r),
        .led_b(led_b),
        .flash_sck(flash_sck),
        .flash_csn(flash_csn),
        .flash_done(flash_done)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #5 vdp_clk = ~vdp_clk;
    end

    function automatic logic [31:0] take_random_bits(input int count);
        logic [31:0] value;
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            // galois step with taps 16 14 13 11
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [23:0] addr);
        return addr[7:0] ^ 8'hA5;
    endfunction

    // a falling csn starts a new command
    always @(negedge flash_csn) begin
        rx_bits = 0;
        tx_bits = 0;
        sck_rises = 0;
    end

    always @(posedge flash_sck) begin
        if (!flash_csn) begin
            sck_rises++;
            if (rx_bits < 32) begin
                spi_rx = {spi_rx[30:0], flash_mosi};
                rx_bits++;
            end
        end
    end

    // data bits change on the falling edge with each byte sent MSB first
    always @(negedge flash_sck) begin
        if (!flash_csn && rx_bits == 32 && tx_bits < 32) begin
            tx_byte = flash_byte(spi_rx[23:0] + 24'(tx_bits / 8));
            flash_miso = tx_byte[7 - tx_bits % 8];
            tx_bits++;
        end
    end

    task automatic finish_run();
        int sva_errors;
        sva_errors = u_dut.u_sva.fail_count;
        $display("errors: %0d value, %0d timeout, %0d assertion",
            value_errors, timeouts, sva_errors);
        if (value_errors + timeouts + sva_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        assert (got === expected) else begin
            value_errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // one host access that starts and ends on a falling edge
    task automatic bus_access(input periph_bus_pkg::addr_t addr,
            input periph_bus_pkg::data_t wdata, input periph_bus_pkg::wstrb_t strb,
            output periph_bus_pkg::data_t rdata);
        int cycles;
        cycles = 0;
        mem_address = addr;
        mem_write_data = wdata;
        mem_wstrb = strb;
        mem_valid = 1'b1;
        @(negedge vdp_clk);
        while (!mem_ready && cycles < bus_timeout) begin
            @(negedge vdp_clk);
            cycles++;
        end
        if (!mem_ready) begin
            timeouts++;
            $display("timeout: no mem_ready for the access at address %h", addr);
            finish_run();
        end
        rdata = mem_read_data;
        // held through the ready cycle, then dropped for one idle cycle
        @(negedge vdp_clk);
        mem_valid = 1'b0;
        mem_wstrb = 4'b0000;
        @(negedge vdp_clk);
    endtask

    task automatic pulse_event(input int source);
        if (source == 0) begin
            frame_ended = 1'b1;
        end else begin
            raster_hit = 1'b1;
        end
        @(negedge vdp_clk);
        frame_ended = 1'b0;
        raster_hit = 1'b0;
        repeat (2) @(negedge vdp_clk);
    endtask

    task automatic check_reset_state();
        check_value("led_r", 32'(led_r), 32'h1);
        check_value("led_b", 32'(led_b), 32'h0);
        check_value("irq", 32'(irq), 32'h0);
        check_value("flash_csn", 32'(flash_csn), 32'h1);
        check_value("mem_ready", 32'(mem_ready), 32'h0);
    endtask

    task automatic check_status();
        periph_bus_pkg::data_t rdata;
        bus_access(24'h100000, 32'h0000_0002, 4'hF, rdata);
        check_value("led_r", 32'(led_r), 32'h0);
        check_value("led_b", 32'(led_b), 32'h1);
        bus_access(24'h100000, 32'h0, 4'h0, rdata);
        check_value("mem_read_data (status)", rdata, 32'h2);
    endtask

    task automatic check_multiplier(input int count);
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic signed [31:0] expected;
        periph_bus_pkg::data_t rdata;
        periph_bus_pkg::addr_t addr_b;
        int k;
        addr_b = 24'h200000 | (24'd1 << periph_bus_pkg::dsp_operand_b_bit);
        for (k = 0; k < count; k++) begin
            a = 16'(take_random_bits(16));
            b = 16'(take_random_bits(16));
            expected = a * b;
            bus_access(24'h200000, {16'h0, a}, 4'hF, rdata);
            bus_access(addr_b, {16'h0, b}, 4'hF, rdata);
            bus_access(24'h200000, 32'h0, 4'h0, rdata);
            check_value("mem_read_data (product)", rdata, expected);
        end
    endtask

    task automatic check_interrupts();
        periph_bus_pkg::data_t rdata;
        pulse_event(0);
        check_value("irq", 32'(irq), 32'h1);
        pulse_event(1);
        check_value("irq", 32'(irq), 32'h3);
        bus_access(24'h300000, 32'h1, 4'h1, rdata);
        check_value("irq", 32'(irq), 32'h2);
        bus_access(24'h300000, 32'h0, 4'h0, rdata);
        check_value("mem_read_data (pending)", rdata, 32'h2);
        bus_access(24'h300000, 32'h2, 4'h1, rdata);
        check_value("irq", 32'(irq), 32'h0);
    endtask

    task automatic check_flash_read(input int count);
        periph_bus_pkg::addr_t addr;
        periph_bus_pkg::data_t expected;
        periph_bus_pkg::data_t rdata;
        logic [23:0] spi_addr;
        int k;
        int i;
        for (k = 0; k < count; k++) begin
            addr = {periph_bus_pkg::region_flash, 18'(take_random_bits(18)), 2'b00};
            spi_addr = addr & ((24'd1 << flash_addr_bits) - 24'd1);
            for (i = 0; i < 4; i++) begin
                expected[8*i +: 8] = (spi_addr[7:0] + 8'(i)) ^ 8'hA5;
            end
            bus_access(addr, 32'h0, 4'h0, rdata);
            check_value("flash command", 32'(spi_rx[31:24]), 32'h03);
            check_value("flash address", 32'(spi_rx[23:0]), 32'(spi_addr));
            check_value("flash_sck rising edges", 32'(sck_rises), 32'd64);
            check_value("mem_read_data (flash)", rdata, expected);
        end
        // writes to flash are dropped
        bus_access(addr, take_random_bits(32), 4'hF, rdata);
        check_value("flash_csn", 32'(flash_csn), 32'h1);
    endtask

    task automatic check_unmapped();
        periph_bus_pkg::data_t rdata;
        bus_access({4'hA, 20'(take_random_bits(20))}, 32'h0, 4'h0, rdata);
        check_value("mem_read_data (unmapped)", rdata, 32'h0);
        bus_access({4'h0, 20'(take_random_bits(20))}, 32'h0, 4'h0, rdata);
        check_value("mem_read_data (unmapped)", rdata, 32'h0);
    endtask

    initial begin
        value_errors = 0;
        timeouts = 0;
        lfsr_state = 16'd23;
        vdp_reset = 1'b1;
        mem_valid = 1'b0;
        mem_address = '0;
        mem_write_data = '0;
        mem_wstrb = '0;
        frame_ended = 1'b0;
        raster_hit = 1'b0;
        flash_miso = 1'b0;
        spi_rx = '0;
        tx_byte = '0;
        rx_bits = 0;
        tx_bits = 0;
        sck_rises = 0;

        repeat (16) @(negedge vdp_clk);
        vdp_reset = 1'b0;
        @(negedge vdp_clk);

        check_reset_state();
        check_status();
        check_multiplier(3);
        check_interrupts();
        check_flash_read(2);
        check_unmapped();

        repeat (4) @(negedge vdp_clk);
        finish_run();
    end

endmodule
